/* files.f */
rtl/bpu_pkg.sv
rtl/inst_predecode.sv
rtl/bimodal_table.sv
rtl/tagged_table.sv
rtl/tage_predictor.sv
rtl/btb.sv
rtl/bpu_top.sv
tb/bpu_tb.sv

/* rtl/bimodal_table.sv */
`timescale 1ns/10ps
`default_nettype none

module bimodal_table (
    input  logic                          clk,
    input  logic                          rst,
    // fetch lookup
    input  logic [bpu_pkg::BIM_IDX_W-1:0] rd_idx_i,
    output logic                          taken_o,
    // training from ex
    input  logic                          train_i,
    input  logic [bpu_pkg::BIM_IDX_W-1:0] train_idx_i,
    input  logic                          train_taken_i
);
    import bpu_pkg::*;

    logic [1:0] ctr_q [2**BIM_IDX_W];
    logic [1:0] train_ctr;

    assign taken_o   = ctr_q[rd_idx_i][1];
    assign train_ctr = ctr_q[train_idx_i];  // second read port for training

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**BIM_IDX_W; i++) begin
                ctr_q[i] <= CTR_WEAK_NT;
            end
        end else if (train_i) begin
            // saturating step toward the resolved direction
            if (train_taken_i) begin
                if (train_ctr != CTR_STRONG_T) begin
                    ctr_q[train_idx_i] <= train_ctr + 2'd1;
                end
            end else begin
                if (train_ctr != CTR_STRONG_NT) begin
                    ctr_q[train_idx_i] <= train_ctr - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/bpu_pkg.sv */
`default_nettype none

package bpu_pkg;

    // datapath widths
    localparam int XLEN       = 32;
    localparam int HIST_WIDTH = 16;  // global outcome history

    // predictor geometry
    localparam int BIM_IDX_W        = 9;   // 512 bimodal counters
    localparam int TAB_IDX_W        = 8;   // 256 entries per tagged table
    localparam int TAG_WIDTH        = 10;
    localparam int PARTIAL_TAG_BITS = 6;   // upper tag bits used at lookup

    // target buffer geometry
    localparam int BTB_IDX_W = 8;
    localparam int BTB_TAG_W = 22;  // pc[31:10]

    // rv32 opcodes seen by the predecoder
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // two-bit saturating counter states, msb is the direction
    localparam logic [1:0] CTR_STRONG_NT = 2'b00;
    localparam logic [1:0] CTR_WEAK_NT   = 2'b01;
    localparam logic [1:0] CTR_WEAK_T    = 2'b10;
    localparam logic [1:0] CTR_STRONG_T  = 2'b11;

    // which component supplied the direction
    localparam logic [1:0] PROV_BIMODAL = 2'd0;
    localparam logic [1:0] PROV_T0      = 2'd1;
    localparam logic [1:0] PROV_T1      = 2'd2;

    // one instruction word, read either as a b-type or a j-type encoding
    typedef union packed {
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } inst_u;

endpackage

`default_nettype wire

/* rtl/bpu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module bpu_top (
    input  logic                           clk,
    input  logic                           rst,
    // fetch
    input  logic [bpu_pkg::XLEN-1:0]       if_pc_i,
    input  logic [bpu_pkg::XLEN-1:0]       if_inst_i,
    // ex feedback, one strobe per resolved branch
    input  logic                           ex_branch_valid_i,
    input  logic                           ex_branch_taken_i,
    input  logic                           ex_pdt_true_i,
    input  logic [bpu_pkg::XLEN-1:0]       ex_pc_i,
    input  logic [bpu_pkg::HIST_WIDTH-1:0] ex_history_i,
    input  logic [bpu_pkg::XLEN-1:0]       ex_target_i,
    // prediction
    output logic                           branch_or_not_o,
    output logic                           pdt_res_o,
    output logic [bpu_pkg::XLEN-1:0]       pdt_pc_o,
    output logic [bpu_pkg::HIST_WIDTH-1:0] history_o
);
    import bpu_pkg::*;

    inst_u           if_inst;
    logic            is_branch;
    logic            is_jal;
    logic [XLEN-1:0] offset;
    logic            tage_taken;
    logic            btb_hit;
    logic [XLEN-1:0] btb_target;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] jump_pc;

    assign if_inst = if_inst_i;

    inst_predecode u_predecode (
        .inst_i      (if_inst),
        .is_branch_o (is_branch),
        .is_jal_o    (is_jal),
        .offset_o    (offset)
    );

    tage_predictor u_tage (
        .clk           (clk),
        .rst           (rst),
        .if_pc_i       (if_pc_i),
        .taken_o       (tage_taken),
        .ex_valid_i    (ex_branch_valid_i),
        .ex_taken_i    (ex_branch_taken_i),
        .ex_pdt_true_i (ex_pdt_true_i),
        .ex_pc_i       (ex_pc_i),
        .ex_history_i  (ex_history_i),
        .history_o     (history_o)
    );

    btb u_btb (
        .clk         (clk),
        .rst         (rst),
        .if_pc_i     (if_pc_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target),
        .wr_i        (ex_branch_valid_i && ex_branch_taken_i),
        .wr_pc_i     (ex_pc_i),
        .wr_target_i (ex_target_i)
    );

    assign pc_plus4 = if_pc_i + XLEN'(4);
    assign jump_pc  = btb_hit ? btb_target : (if_pc_i + offset);  // btb overrides decode

    always_comb begin
        branch_or_not_o = 1'b0;
        pdt_res_o       = 1'b0;
        pdt_pc_o        = pc_plus4;
        if (is_jal) begin
            branch_or_not_o = 1'b1;
            pdt_res_o       = 1'b1;  // unconditional
            pdt_pc_o        = jump_pc;
        end else if (is_branch) begin
            branch_or_not_o = 1'b1;
            pdt_res_o       = tage_taken;
            if (tage_taken) begin
                pdt_pc_o = jump_pc;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/btb.sv */
`timescale 1ns/10ps
`default_nettype none

module btb (
    input  logic                     clk,
    input  logic                     rst,
    // fetch lookup
    input  logic [bpu_pkg::XLEN-1:0] if_pc_i,
    output logic                     hit_o,
    output logic [bpu_pkg::XLEN-1:0] target_o,
    // write from taken ex branches
    input  logic                     wr_i,
    input  logic [bpu_pkg::XLEN-1:0] wr_pc_i,
    input  logic [bpu_pkg::XLEN-1:0] wr_target_i
);
    import bpu_pkg::*;

    logic                 valid_q  [2**BTB_IDX_W];
    logic [BTB_TAG_W-1:0] tag_q    [2**BTB_IDX_W];
    logic [XLEN-1:0]      target_q [2**BTB_IDX_W];

    logic [BTB_IDX_W-1:0] rd_idx;
    logic [BTB_TAG_W-1:0] rd_tag;
    logic [BTB_IDX_W-1:0] wr_idx;

    // word aligned, so pc[1:0] is skipped
    assign rd_idx = if_pc_i[BTB_IDX_W+1:2];
    assign rd_tag = if_pc_i[XLEN-1 -: BTB_TAG_W];
    assign wr_idx = wr_pc_i[BTB_IDX_W+1:2];

    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**BTB_IDX_W; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tag and target of the written entry
    always_ff @(posedge clk) begin
        if (wr_i) begin
            tag_q[wr_idx]    <= wr_pc_i[XLEN-1 -: BTB_TAG_W];
            target_q[wr_idx] <= wr_target_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/inst_predecode.sv */
`timescale 1ns/10ps
`default_nettype none

module inst_predecode (
    input  bpu_pkg::inst_u           inst_i,
    output logic                     is_branch_o,
    output logic                     is_jal_o,
    output logic [bpu_pkg::XLEN-1:0] offset_o
);
    import bpu_pkg::*;

    logic [XLEN-1:0] b_offset;
    logic [XLEN-1:0] j_offset;

    // opcode sits in the same bits in both views
    assign is_branch_o = (inst_i.b.opcode == OPC_BRANCH);
    assign is_jal_o    = (inst_i.j.opcode == OPC_JAL);

    // 13-bit branch displacement, bit 0 always zero
    assign b_offset = {{(XLEN-12){inst_i.b.imm12}},
                       inst_i.b.imm11,
                       inst_i.b.imm10_5,
                       inst_i.b.imm4_1,
                       1'b0};

    // 21-bit jump displacement
    assign j_offset = {{(XLEN-20){inst_i.j.imm20}},
                       inst_i.j.imm19_12,
                       inst_i.j.imm11,
                       inst_i.j.imm10_1,
                       1'b0};

    always_comb begin
        if (is_branch_o) begin
            offset_o = b_offset;
        end else if (is_jal_o) begin
            offset_o = j_offset;
        end else begin
            offset_o = '0;  // not a control transfer
        end
    end

endmodule

`default_nettype wire

/* rtl/tage_predictor.sv */
`timescale 1ns/10ps
`default_nettype none

module tage_predictor (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [bpu_pkg::XLEN-1:0]       if_pc_i,
    output logic                           taken_o,
    // resolved branch from ex
    input  logic                           ex_valid_i,
    input  logic                           ex_taken_i,
    input  logic                           ex_pdt_true_i,
    input  logic [bpu_pkg::XLEN-1:0]       ex_pc_i,
    input  logic [bpu_pkg::HIST_WIDTH-1:0] ex_history_i,
    output logic [bpu_pkg::HIST_WIDTH-1:0] history_o
);
    import bpu_pkg::*;

    logic [HIST_WIDTH-1:0] hist_q;

    logic                  t0_hit, t0_taken, t0_upd_hit, t0_upd_tag_eq;
    logic                  t1_hit, t1_taken, t1_upd_hit, t1_upd_tag_eq;
    logic                  bim_taken;
    logic [1:0]            prov;
    logic [1:0]            upd_prov;
    logic                  upd_mispred;

    // short history for t0
    function automatic logic [TAB_IDX_W-1:0] t0_index(input logic [XLEN-1:0] pc,
                                                      input logic [HIST_WIDTH-1:0] hist);
        return pc[TAB_IDX_W-1:0] ^ hist[TAB_IDX_W-1:0];
    endfunction

    function automatic logic [TAB_IDX_W-1:0] t1_index(input logic [XLEN-1:0] pc,
                                                      input logic [HIST_WIDTH-1:0] hist);
        return pc[TAB_IDX_W-1:0] ^ hist[HIST_WIDTH-1 -: TAB_IDX_W];
    endfunction

    function automatic logic [TAG_WIDTH-1:0] t0_tag(input logic [XLEN-1:0] pc,
                                                    input logic [HIST_WIDTH-1:0] hist);
        return pc[TAB_IDX_W +: TAG_WIDTH] ^ hist[HIST_WIDTH-1 -: TAG_WIDTH];
    endfunction

    function automatic logic [TAG_WIDTH-1:0] t1_tag(input logic [XLEN-1:0] pc,
                                                    input logic [HIST_WIDTH-1:0] hist);
        return pc[TAB_IDX_W +: TAG_WIDTH] ^
               {{(TAG_WIDTH-TAB_IDX_W){1'b0}}, hist[TAB_IDX_W-1:0]};
    endfunction

    // newest outcome enters at bit 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_q <= '0;
        end else if (ex_valid_i) begin
            hist_q <= {hist_q[HIST_WIDTH-2:0], ex_taken_i};
        end
    end

    assign history_o = hist_q;

    // longest matching history wins
    assign prov = t1_hit ? PROV_T1 : (t0_hit ? PROV_T0 : PROV_BIMODAL);

    always_comb begin
        case (prov)
            PROV_T1: taken_o = t1_taken;
            PROV_T0: taken_o = t0_taken;
            default: taken_o = bim_taken;
        endcase
    end

    // provider recomputed from the ex-side pc and history
    assign upd_prov    = t1_upd_hit ? PROV_T1 : (t0_upd_hit ? PROV_T0 : PROV_BIMODAL);
    assign upd_mispred = ex_valid_i && !ex_pdt_true_i;

    bimodal_table bim_table (
        .clk           (clk),
        .rst           (rst),
        .rd_idx_i      (if_pc_i[BIM_IDX_W:1]),
        .taken_o       (bim_taken),
        .train_i       (ex_valid_i),  // base counter trains on every branch
        .train_idx_i   (ex_pc_i[BIM_IDX_W:1]),
        .train_taken_i (ex_taken_i)
    );

    tagged_table t0_table (
        .clk          (clk),
        .rst          (rst),
        .rd_idx_i     (t0_index(if_pc_i, hist_q)),
        .rd_tag_i     (t0_tag(if_pc_i, hist_q)),
        .hit_o        (t0_hit),
        .taken_o      (t0_taken),
        .upd_idx_i    (t0_index(ex_pc_i, ex_history_i)),
        .upd_tag_i    (t0_tag(ex_pc_i, ex_history_i)),
        .upd_tag_eq_o (t0_upd_tag_eq),
        .upd_hit_o    (t0_upd_hit),
        .train_i      (ex_valid_i && ex_pdt_true_i && upd_prov == PROV_T0),
        .force_i      (upd_mispred && upd_prov == PROV_T0),
        .alloc_i      (upd_mispred && upd_prov == PROV_BIMODAL
                       && t1_upd_tag_eq && !t0_upd_tag_eq),  // t1 slot already owned
        .upd_taken_i  (ex_taken_i)
    );

    tagged_table t1_table (
        .clk          (clk),
        .rst          (rst),
        .rd_idx_i     (t1_index(if_pc_i, hist_q)),
        .rd_tag_i     (t1_tag(if_pc_i, hist_q)),
        .hit_o        (t1_hit),
        .taken_o      (t1_taken),
        .upd_idx_i    (t1_index(ex_pc_i, ex_history_i)),
        .upd_tag_i    (t1_tag(ex_pc_i, ex_history_i)),
        .upd_tag_eq_o (t1_upd_tag_eq),
        .upd_hit_o    (t1_upd_hit),
        .train_i      (ex_valid_i && ex_pdt_true_i && upd_prov == PROV_T1),
        .force_i      (upd_mispred && upd_prov == PROV_T1),
        .alloc_i      (upd_mispred && upd_prov == PROV_BIMODAL && !t1_upd_tag_eq),
        .upd_taken_i  (ex_taken_i)
    );

endmodule

`default_nettype wire

/* rtl/tagged_table.sv */
`timescale 1ns/10ps
`default_nettype none

module tagged_table (
    input  logic                          clk,
    input  logic                          rst,
    // fetch lookup
    input  logic [bpu_pkg::TAB_IDX_W-1:0] rd_idx_i,
    input  logic [bpu_pkg::TAG_WIDTH-1:0] rd_tag_i,
    output logic                          hit_o,
    output logic                          taken_o,
    // update side lookup
    input  logic [bpu_pkg::TAB_IDX_W-1:0] upd_idx_i,
    input  logic [bpu_pkg::TAG_WIDTH-1:0] upd_tag_i,
    output logic                          upd_tag_eq_o,
    output logic                          upd_hit_o,
    // update commands, at most one per strobe
    input  logic                          train_i,
    input  logic                          force_i,
    input  logic                          alloc_i,
    input  logic                          upd_taken_i
);
    import bpu_pkg::*;

    logic [TAG_WIDTH-1:0] tag_q [2**TAB_IDX_W];
    logic [1:0]           ctr_q [2**TAB_IDX_W];

    logic [TAG_WIDTH-1:0] rd_tag_stored;
    logic [TAG_WIDTH-1:0] upd_tag_stored;
    logic [1:0]           upd_ctr;

    assign rd_tag_stored  = tag_q[rd_idx_i];
    assign upd_tag_stored = tag_q[upd_idx_i];
    assign upd_ctr        = ctr_q[upd_idx_i];

    // only the upper tag bits take part in a lookup
    assign hit_o = (rd_tag_stored[TAG_WIDTH-1 -: PARTIAL_TAG_BITS] ==
                    rd_tag_i[TAG_WIDTH-1 -: PARTIAL_TAG_BITS]);
    assign taken_o = ctr_q[rd_idx_i][1];

    assign upd_hit_o = (upd_tag_stored[TAG_WIDTH-1 -: PARTIAL_TAG_BITS] ==
                        upd_tag_i[TAG_WIDTH-1 -: PARTIAL_TAG_BITS]);
    assign upd_tag_eq_o = (upd_tag_stored == upd_tag_i);  // full compare, for allocation

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**TAB_IDX_W; i++) begin
                tag_q[i] <= '0;
                ctr_q[i] <= CTR_WEAK_NT;
            end
        end else if (alloc_i) begin
            // new entry starts weak in the observed direction
            tag_q[upd_idx_i] <= upd_tag_i;
            ctr_q[upd_idx_i] <= upd_taken_i ? CTR_WEAK_T : CTR_WEAK_NT;
        end else if (force_i) begin
            ctr_q[upd_idx_i] <= upd_taken_i ? CTR_STRONG_T : CTR_STRONG_NT;
        end else if (train_i) begin
            if (upd_taken_i) begin
                if (upd_ctr != CTR_STRONG_T) begin
                    ctr_q[upd_idx_i] <= upd_ctr + 2'd1;
                end
            end else begin
                if (upd_ctr != CTR_STRONG_NT) begin
                    ctr_q[upd_idx_i] <= upd_ctr - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# compile with verilator and run; pass only when the pass message is printed
verilator --binary --top-module bpu_tb -f files.f -o bpu_sim \
    && ./obj_dir/bpu_sim | tee /dev/stderr | grep -q "All tests passed" \
    && echo "simulation PASSED" \
    || { echo "simulation FAILED"; exit 1; }

/* tb/bpu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module bpu_tb;
    import bpu_pkg::*;

    localparam int          CLK_PERIOD  = 20;
    localparam int          MAX_CYCLES  = 3000;  // directed phase + 2000 random, with margin
    localparam int          RAND_CYCLES = 2000;
    localparam logic [31:0] SEED        = 32'h336e_812a;
    localparam logic [31:0] NOP         = 32'h0000_0013;

    logic                  clk = 1'b0;
    logic                  rst;
    logic [XLEN-1:0]       if_pc, if_inst, ex_pc, ex_target;
    logic                  ex_valid, ex_taken, ex_pdt_true;
    logic [HIST_WIDTH-1:0] ex_history;
    logic                  branch_or_not, pdt_res;
    logic [XLEN-1:0]       pdt_pc;
    logic [HIST_WIDTH-1:0] history;
    int                    value_errors = 0;
    int                    cycles = 0;

    // reference model state
    logic [1:0]            m_bim [2**BIM_IDX_W];
    logic [9:0]            m_t0_tag [256];
    logic [9:0]            m_t1_tag [256];
    logic [1:0]            m_t0_ctr [256];
    logic [1:0]            m_t1_ctr [256];
    logic                  m_btb_valid [256];
    logic [21:0]           m_btb_tag [256];
    logic [31:0]           m_btb_target [256];
    logic [15:0]           m_hist;

    bpu_top UUT (
        .clk               (clk),
        .rst               (rst),
        .if_pc_i           (if_pc),
        .if_inst_i         (if_inst),
        .ex_branch_valid_i (ex_valid),
        .ex_branch_taken_i (ex_taken),
        .ex_pdt_true_i     (ex_pdt_true),
        .ex_pc_i           (ex_pc),
        .ex_history_i      (ex_history),
        .ex_target_i       (ex_target),
        .branch_or_not_o   (branch_or_not),
        .pdt_res_o         (pdt_res),
        .pdt_pc_o          (pdt_pc),
        .history_o         (history)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic logic [1:0] saturate(input logic [1:0] ctr, input logic up);
        if (up) begin
            return (ctr == 2'b11) ? ctr : ctr + 2'd1;
        end
        return (ctr == 2'b00) ? ctr : ctr - 2'd1;
    endfunction

    // {branch_or_not, pdt_res, pdt_pc, history}
    function automatic logic [49:0] expected_outputs(input logic [31:0] pc,
                                                     input logic [31:0] inst);
        logic [7:0]  i0, i1;
        logic [9:0]  g0, g1;
        logic [7:0]  bi;
        logic [31:0] off, jump;
        logic        dir, hit;
        i0  = pc[7:0] ^ m_hist[7:0];
        i1  = pc[7:0] ^ m_hist[15:8];
        g0  = pc[17:8] ^ m_hist[15:6];
        g1  = pc[17:8] ^ {2'b00, m_hist[7:0]};
        bi  = pc[9:2];
        off = (inst[6:0] == OPC_JAL) ?
              {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0} :
              {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        if (m_t1_tag[i1][9:4] == g1[9:4]) begin
            dir = m_t1_ctr[i1][1];
        end else if (m_t0_tag[i0][9:4] == g0[9:4]) begin
            dir = m_t0_ctr[i0][1];
        end else begin
            dir = m_bim[pc[9:1]][1];
        end
        hit  = m_btb_valid[bi] && (m_btb_tag[bi] == pc[31:10]);
        jump = hit ? m_btb_target[bi] : pc + off;
        if (inst[6:0] == OPC_JAL) begin
            return {2'b11, jump, m_hist};
        end else if (inst[6:0] == OPC_BRANCH) begin
            return {1'b1, dir, dir ? jump : pc + 32'd4, m_hist};
        end
        return {2'b00, pc + 32'd4, m_hist};
    endfunction

    task automatic update_model();
        logic [7:0] i0, i1;
        logic [9:0] g0, g1;
        logic       h0, h1;
        i0 = ex_pc[7:0] ^ ex_history[7:0];
        i1 = ex_pc[7:0] ^ ex_history[15:8];
        g0 = ex_pc[17:8] ^ ex_history[15:6];
        g1 = ex_pc[17:8] ^ {2'b00, ex_history[7:0]};
        h0 = (m_t0_tag[i0][9:4] == g0[9:4]);
        h1 = (m_t1_tag[i1][9:4] == g1[9:4]);
        m_bim[ex_pc[9:1]] = saturate(m_bim[ex_pc[9:1]], ex_taken);
        if (h1) begin
            m_t1_ctr[i1] = ex_pdt_true ? saturate(m_t1_ctr[i1], ex_taken) : {2{ex_taken}};
        end else if (h0) begin
            m_t0_ctr[i0] = ex_pdt_true ? saturate(m_t0_ctr[i0], ex_taken) : {2{ex_taken}};
        end else if (!ex_pdt_true) begin
            if (m_t1_tag[i1] != g1) begin
                m_t1_tag[i1] = g1;
                m_t1_ctr[i1] = {ex_taken, ~ex_taken};  // weak toward outcome
            end else if (m_t0_tag[i0] != g0) begin
                m_t0_tag[i0] = g0;
                m_t0_ctr[i0] = {ex_taken, ~ex_taken};
            end
        end
        if (ex_taken) begin
            m_btb_valid[ex_pc[9:2]]  = 1'b1;
            m_btb_tag[ex_pc[9:2]]    = ex_pc[31:10];
            m_btb_target[ex_pc[9:2]] = ex_target;
        end
        m_hist = {m_hist[14:0], ex_taken};
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**BIM_IDX_W; i++) begin
                m_bim[i] = 2'b01;
            end
            for (int i = 0; i < 256; i++) begin
                m_t0_tag[i]    = '0;
                m_t1_tag[i]    = '0;
                m_t0_ctr[i]    = 2'b01;
                m_t1_ctr[i]    = 2'b01;
                m_btb_valid[i] = 1'b0;
            end
            m_hist = '0;
        end else if (ex_valid) begin
            update_model();
        end
    end

    // compare shortly before the next edge, inputs settled since +2 ns
    always begin
        logic [49:0] exp_out;
        @(posedge clk);
        #(CLK_PERIOD - 2);
        if (!rst) begin
            exp_out = expected_outputs(if_pc, if_inst);
            if (branch_or_not !== exp_out[49]) begin
                $display("** Error at %0t: branch_or_not_o expected %b got %b",
                         $time, exp_out[49], branch_or_not);
                value_errors++;
            end
            if (pdt_res !== exp_out[48]) begin
                $display("** Error at %0t: pdt_res_o expected %b got %b",
                         $time, exp_out[48], pdt_res);
                value_errors++;
            end
            if (pdt_pc !== exp_out[47:16]) begin
                $display("** Error at %0t: pdt_pc_o expected %h got %h",
                         $time, exp_out[47:16], pdt_pc);
                value_errors++;
            end
            if (history !== exp_out[15:0]) begin
                $display("** Error at %0t: history_o expected %h got %h",
                         $time, exp_out[15:0], history);
                value_errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("run timed out after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic strobe(input logic [31:0] pc, input logic taken, input logic pdt_true,
                          input logic [15:0] hist, input logic [31:0] target);
        ex_valid    = 1'b1;
        ex_pc       = pc;
        ex_taken    = taken;
        ex_pdt_true = pdt_true;
        ex_history  = hist;
        ex_target   = target;
        next_cycle();
        ex_valid = 1'b0;
    endtask

    function automatic logic [31:0] branch_inst(input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jal_inst(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, OPC_JAL};
    endfunction

    task automatic random_stream();
        logic [31:0] pool [8];
        int          kind;
        for (int k = 0; k < 8; k++) begin
            pool[k] = 32'h0001_0000 * (k % 4) + 32'h400 * (k / 4) + 32'h80 + 32'(4 * (k % 2));
        end
        for (int n = 0; n < RAND_CYCLES; n++) begin
            kind    = $urandom_range(0, 3);
            if_pc   = pool[$urandom_range(0, 7)];
            if_inst = (kind == 0) ? NOP :
                      (kind == 1) ? branch_inst(13'($urandom_range(0, 8191))) :
                      (kind == 2) ? jal_inst(21'($urandom())) : $urandom();
            ex_valid    = 1'($urandom_range(0, 1));
            ex_pc       = pool[$urandom_range(0, 7)];
            ex_taken    = 1'($urandom_range(0, 1));
            ex_pdt_true = 1'($urandom_range(0, 1));
            ex_history  = ($urandom_range(0, 1) == 1) ? m_hist : 16'($urandom());
            ex_target   = $urandom() & 32'hffff_fffc;
            next_cycle();
        end
        ex_valid = 1'b0;
    endtask

    initial begin
        logic [15:0] h_alloc;
        void'($urandom(SEED));
        rst         = 1'b1;
        if_pc       = 32'h100;
        if_inst     = NOP;
        ex_valid    = 1'b0;
        ex_taken    = 1'b0;
        ex_pdt_true = 1'b0;
        ex_pc       = '0;
        ex_history  = '0;
        ex_target   = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        // after reset: non-branch, branch, jal
        next_cycle();
        if_inst = branch_inst(13'h040);
        next_cycle();
        if_inst = jal_inst(21'h1_0200);
        next_cycle();
        // bimodal training and btb redirect, no tagged entry involved
        strobe(32'h0001_0200, 1'b1, 1'b1, 16'h0, 32'h1234_5670);
        strobe(32'h0001_0200, 1'b1, 1'b1, 16'h0, 32'h1234_5670);
        if_pc   = 32'h0001_0200;
        if_inst = branch_inst(13'h080);
        #15;
        if (pdt_res !== 1'b1 || pdt_pc !== 32'h1234_5670) begin
            $display("** Error at %0t: pdt_pc_o expected %h got %h (pdt_res_o %b)",
                     $time, 32'h1234_5670, pdt_pc, pdt_res);
            value_errors++;
        end
        next_cycle();
        // btb alias with other upper bits
        if_pc = 32'h0001_0600;
        next_cycle();
        strobe(32'h0001_0600, 1'b1, 1'b0, m_hist, 32'h0000_9990);
        next_cycle();
        if_pc = 32'h0001_0200;
        next_cycle();
        // bimodal at the t1 test pc leans strongly not taken
        strobe(32'h0003_0310, 1'b0, 1'b1, 16'h0, 32'h0000_4440);
        strobe(32'h0003_0310, 1'b0, 1'b1, 16'h0, 32'h0000_4440);
        // steer history so it alternates between two values from here on
        for (int b = 15; b >= 0; b--) begin
            strobe(32'h0000_0800, 1'(16'haaaa >> b), 1'b1, m_hist, 32'h900);
        end
        // bimodal mispredict allocates t1 under the history seen afterwards
        h_alloc = {m_hist[14:0], 1'b1};
        strobe(32'h0003_0310, 1'b1, 1'b0, h_alloc, 32'h0000_4440);
        if_pc   = 32'h0003_0310;
        if_inst = branch_inst(13'h1f00);
        next_cycle();  // t1 says taken while bimodal says not taken
        // t1 mispredict forces strong not taken, one taken step keeps it not taken
        strobe(32'h0003_0310, 1'b0, 1'b0, h_alloc, 32'h0000_4440);
        strobe(32'h0003_0310, 1'b1, 1'b1, h_alloc, 32'h0000_4440);
        next_cycle();
        // history holds without strobes
        repeat (4) next_cycle();
        random_stream();
        repeat (3) next_cycle();
        $display("errors: %0d output mismatches", value_errors);
        if (value_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
